// ==== sources.f ====
io_pkg.sv
cpu_bus_if.sv
ctrl_status_regs.sv
cycle_counters.sv
cpu_read_port.sv
cpu_io_top.sv
cpu_io_sva.sv
cpu_io_tb.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        := cpu_io_tb
FILELIST   := sources.f
VFLAGS     := --binary --timing --assert
LINT_FLAGS := --lint-only --timing --assert
OBJ_DIR    := obj_dir
LOG        := sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== cpu_io_tb.sv ====
module cpu_io_tb;

    localparam logic [3:0] FPGA_ID  = 4'h5;
    localparam logic [3:0] CLOCK_ID = 4'h3;
    localparam logic [3:0] FPGA_VER = 4'hA;

    localparam int PERIOD = 100;
    // rough sum of the cycles the tests take, and the slack on top
    localparam int TEST_CYCLES = 100;
    localparam int MARGIN      = 4;

    // counter bracket lengths
    localparam int ENA_GAP    = 5;
    localparam int FREEZE_GAP = 3;
    // no register listens to this op bit
    localparam int UNUSED_OP_BIT = 11;

    logic           cpu_clk;
    logic           reset;
    io_pkg::op_t    op;
    io_pkg::stack_t tos;
    logic           rd_reg;
    logic           wr_reg;
    logic           wr_evt;
    logic           adc_ovfl;
    logic           host_srq;
    io_pkg::word_t  host_dout;
    io_pkg::word_t  par;
    logic           ser;
    logic           osc_en;
    logic           eeprom_wp;
    logic           interrupt;

    logic [15:0]    lfsr_state;

    cpu_io_top #(
        .FPGA_ID  (FPGA_ID),
        .CLOCK_ID (CLOCK_ID),
        .FPGA_VER (FPGA_VER)
    ) dut (
        .cpu_clk   (cpu_clk),
        .reset     (reset),
        .op        (op),
        .tos       (tos),
        .rd_reg    (rd_reg),
        .wr_reg    (wr_reg),
        .wr_evt    (wr_evt),
        .adc_ovfl  (adc_ovfl),
        .host_srq  (host_srq),
        .host_dout (host_dout),
        .par       (par),
        .ser       (ser),
        .osc_en    (osc_en),
        .eeprom_wp (eeprom_wp),
        .interrupt (interrupt)
    );

    //////////////////////////////////////////////////
    // clock and watchdog

    initial
    begin
        cpu_clk = 1'b0;
        forever #(PERIOD / 2) cpu_clk = ~cpu_clk;
    end

    initial
    begin
        #(TEST_CYCLES * MARGIN * PERIOD);
        $display("timeout: the tests did not finish in the expected number of cycles");
        $display("TEST FAIL");
        $fatal(1, "watchdog expired");
    end

    //////////////////////////////////////////////////
    // helpers

    // x^16 + x^14 + x^13 + x^11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one lfsr step per bit taken
    task automatic take_bits(input int n, output logic [31:0] bits);
        int i;
        bits = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr_state = lfsr_next(lfsr_state);
            bits = {bits[30:0], lfsr_state[0]};
        end
    endtask

    function automatic io_pkg::op_t op_bit(input int b);
        return io_pkg::op_t'(1) << b;
    endfunction

    // flag, three zero bits, version, clock id, fpga id
    function automatic io_pkg::word_t status_word(input logic flag);
        return {flag, 3'b000, FPGA_VER, CLOCK_ID, FPGA_ID};
    endfunction

    task automatic check(input string name, input logic [31:0] actual,
                         input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("** Error %s: got 0x%h, expected 0x%h", name, actual, expected);
            $display("TEST FAIL");
            $fatal(1, "stopped at the first failed check");
        end
    endtask

    // strobes change on the falling edge only
    task automatic drive_bus(input io_pkg::op_t op_v, input logic rd, input logic wr,
                             input logic evt);
        @(negedge cpu_clk);
        op     = op_v;
        rd_reg = rd;
        wr_reg = wr;
        wr_evt = evt;
    endtask

    task automatic idle_cycle();
        drive_bus('0, 1'b0, 1'b0, 1'b0);
    endtask

    // par is combinational, give it a moment to settle
    task automatic sample_par(input string name, input io_pkg::word_t expected);
        #(PERIOD / 10);
        check(name, 32'(par), 32'(expected));
    endtask

    task automatic read_par(input io_pkg::op_t op_v, input io_pkg::word_t expected);
        drive_bus(op_v, 1'b1, 1'b0, 1'b0);
        sample_par("par", expected);
    endtask

    //////////////////////////////////////////////////
    // directed tests

    task automatic reset_defaults();
        check("osc_en", 32'(osc_en), 32'd0);
        check("eeprom_wp", 32'(eeprom_wp), 32'd0);
        check("interrupt", 32'(interrupt), 32'd0);
        check("ser", 32'(ser), 32'd0);
        read_par(op_bit(io_pkg::OP_GET_STATUS), status_word(1'b0));
        idle_cycle();
    endtask

    task automatic ctrl_writes();
        logic [31:0] val;
        int n;
        for (n = 0; n < 4; n++)
        begin
            take_bits(32, val);
            drive_bus(op_bit(io_pkg::OP_SET_CTRL), 1'b0, 1'b1, 1'b0);
            tos = val;
            // visible after the edge that takes the write
            idle_cycle();
            check("osc_en", 32'(osc_en), 32'(val[io_pkg::CTRL_OSC_EN]));
            check("eeprom_wp", 32'(eeprom_wp), 32'(val[io_pkg::CTRL_EEPROM_WP]));
            check("interrupt", 32'(interrupt), 32'(val[io_pkg::CTRL_INTERRUPT]));
        end
        // register write with another op bit leaves ctrl alone
        drive_bus(op_bit(io_pkg::OP_GET_STATUS), 1'b0, 1'b1, 1'b0);
        tos = ~val;
        idle_cycle();
        check("osc_en", 32'(osc_en), 32'(val[io_pkg::CTRL_OSC_EN]));
        check("eeprom_wp", 32'(eeprom_wp), 32'(val[io_pkg::CTRL_EEPROM_WP]));
        check("interrupt", 32'(interrupt), 32'(val[io_pkg::CTRL_INTERRUPT]));
    endtask

    task automatic overflow_flag();
        // single pulse
        idle_cycle();
        adc_ovfl = 1'b1;
        idle_cycle();
        adc_ovfl = 1'b0;
        read_par(op_bit(io_pkg::OP_GET_STATUS), status_word(1'b1));
        // sticky
        read_par(op_bit(io_pkg::OP_GET_STATUS), status_word(1'b1));
        drive_bus(op_bit(io_pkg::OP_CLR_RX_OVFL), 1'b0, 1'b0, 1'b1);
        idle_cycle();
        read_par(op_bit(io_pkg::OP_GET_STATUS), status_word(1'b0));
        // overflow on the same edge as the clear survives it
        drive_bus(op_bit(io_pkg::OP_CLR_RX_OVFL), 1'b0, 1'b0, 1'b1);
        adc_ovfl = 1'b1;
        idle_cycle();
        adc_ovfl = 1'b0;
        read_par(op_bit(io_pkg::OP_GET_STATUS), status_word(1'b1));
        drive_bus(op_bit(io_pkg::OP_CLR_RX_OVFL), 1'b0, 1'b0, 1'b1);
        idle_cycle();
        read_par(op_bit(io_pkg::OP_GET_STATUS), status_word(1'b0));
    endtask

    task automatic service_requests();
        // flush anything left over
        drive_bus(op_bit(io_pkg::OP_GET_SRQ), 1'b1, 1'b0, 1'b0);
        idle_cycle();
        check("ser", 32'(ser), 32'd0);
        host_srq = 1'b1;
        idle_cycle();
        host_srq = 1'b0;
        idle_cycle();
        drive_bus(op_bit(io_pkg::OP_GET_SRQ), 1'b1, 1'b0, 1'b0);
        idle_cycle();
        check("ser", 32'(ser), 32'd1);
        // nothing new since the last read
        drive_bus(op_bit(io_pkg::OP_GET_SRQ), 1'b1, 1'b0, 1'b0);
        idle_cycle();
        check("ser", 32'(ser), 32'd0);
    endtask

    task automatic cycle_counting();
        io_pkg::count_t exp0;
        io_pkg::count_t exp1;
        io_pkg::word_t  exp_par;
        int k;
        drive_bus(op_bit(io_pkg::OP_CPU_CTR_CLR), 1'b0, 1'b0, 1'b1);
        drive_bus(op_bit(io_pkg::OP_CPU_CTR_ENA), 1'b0, 1'b0, 1'b1);
        repeat (ENA_GAP) idle_cycle();
        drive_bus(op_bit(io_pkg::OP_CPU_CTR_DIS), 1'b0, 1'b0, 1'b1);
        repeat (FREEZE_GAP) idle_cycle();
        // counter 1 counts from the edge after enable through the disable edge
        exp1 = io_pkg::count_t'(ENA_GAP + 1);
        for (k = 0; k < 4; k++)
        begin
            // edges since the clear, one more for every byte read
            exp0 = io_pkg::count_t'(ENA_GAP + FREEZE_GAP + 2 + k);
            exp_par = {8'(exp1 >> (8 * k)), 8'(exp0 >> (8 * k))};
            read_par(op_bit(io_pkg::OP_GET_CPU_CTR0 + k), exp_par);
        end
        // still frozen a few cycles later
        repeat (FREEZE_GAP) idle_cycle();
        drive_bus(op_bit(io_pkg::OP_GET_CPU_CTR0), 1'b1, 1'b0, 1'b0);
        #(PERIOD / 10);
        check("par[15:8]", 32'(par[15:8]), 32'(exp1[7:0]));
        idle_cycle();
    endtask

    task automatic fall_through_case(input io_pkg::op_t op_v, input logic rd);
        logic [31:0] val;
        take_bits(16, val);
        drive_bus(op_v, rd, 1'b0, 1'b0);
        host_dout = val[15:0];
        sample_par("par", val[15:0]);
    endtask

    task automatic host_fall_through();
        fall_through_case(op_bit(io_pkg::OP_GET_STATUS), 1'b0);
        fall_through_case(op_bit(io_pkg::OP_GET_CPU_CTR2), 1'b0);
        fall_through_case(op_bit(UNUSED_OP_BIT), 1'b1);
        fall_through_case(op_bit(io_pkg::OP_SET_CTRL), 1'b1);
        fall_through_case('0, 1'b1);
        idle_cycle();
    endtask

    //////////////////////////////////////////////////
    // main sequence

    initial
    begin
        reset      = 1'b1;
        op         = '0;
        tos        = '0;
        rd_reg     = 1'b0;
        wr_reg     = 1'b0;
        wr_evt     = 1'b0;
        adc_ovfl   = 1'b0;
        host_srq   = 1'b0;
        host_dout  = '0;
        lfsr_state = 16'd72;
        repeat (2) @(posedge cpu_clk);
        @(negedge cpu_clk);
        reset = 1'b0;

        reset_defaults();
        ctrl_writes();
        overflow_flag();
        service_requests();
        cycle_counting();
        host_fall_through();

        // the bound assertions keep their own count
        if (dut.u_regs.u_sva.fail_count == 0)
        begin
            $display("TEST PASS");
            $finish;
        end
        else
        begin
            $display("TEST FAIL");
            $fatal(1, "assertion failures recorded");
        end
    end

endmodule

// ==== cpu_io_sva.sv ====
module cpu_io_sva (
    input logic          cpu_clk,
    input logic          reset,
    input logic          set_ctrl,
    input logic          clr_ovfl,
    input logic          adc_ovfl,
    input logic          rx_overflow,
    input io_pkg::word_t ctrl
);

    // read back by the testbench at the end of the run
    int fail_count = 0;

    // ctrl moves only on the edge after a SET_CTRL write
    ctrl_hold: assert property (@(posedge cpu_clk) disable iff (reset)
        !$past(set_ctrl) |-> $stable(ctrl))
    else
    begin
        fail_count = fail_count + 1;
        $error("ctrl changed without a SET_CTRL write");
    end

    // any overflow pulse sets the flag
    ovfl_set: assert property (@(posedge cpu_clk) disable iff (reset)
        adc_ovfl && !clr_ovfl |=> rx_overflow)
    else
    begin
        fail_count = fail_count + 1;
        $error("overflow flag not set after adc_ovfl");
    end

    // clear with no new overflow
    ovfl_clear: assert property (@(posedge cpu_clk) disable iff (reset)
        clr_ovfl && !adc_ovfl |=> !rx_overflow)
    else
    begin
        fail_count = fail_count + 1;
        $error("overflow flag not cleared");
    end

    ovfl_reset: assert property (@(posedge cpu_clk) reset |=> !rx_overflow)
    else
    begin
        fail_count = fail_count + 1;
        $error("overflow flag high after reset");
    end

endmodule

bind ctrl_status_regs cpu_io_sva u_sva (
    .cpu_clk     (cpu_clk),
    .reset       (reset),
    .set_ctrl    (set_ctrl),
    .clr_ovfl    (clr_ovfl),
    .adc_ovfl    (adc_ovfl),
    .rx_overflow (rx_overflow),
    .ctrl        (ctrl)
);

// ==== cpu_io_top.sv ====
module cpu_io_top #(
    parameter logic [io_pkg::ID_W-1:0] FPGA_ID  = 4'd1,
    parameter logic [io_pkg::ID_W-1:0] CLOCK_ID = 4'd0,
    parameter logic [io_pkg::ID_W-1:0] FPGA_VER = 4'd1
) (
    input  logic           cpu_clk,
    input  logic           reset,
    input  io_pkg::op_t    op,
    input  io_pkg::stack_t tos,
    input  logic           rd_reg,
    input  logic           wr_reg,
    input  logic           wr_evt,
    input  logic           adc_ovfl,
    input  logic           host_srq,
    input  io_pkg::word_t  host_dout,
    output io_pkg::word_t  par,
    output logic           ser,
    output logic           osc_en,
    output logic           eeprom_wp,
    output logic           interrupt
);

    io_pkg::word_t  ctrl;
    io_pkg::word_t  status;
    io_pkg::count_t ctr0;
    io_pkg::count_t ctr1;

    //////////////////////////////////////////////////
    // cpu bus

    cpu_bus_if bus ();

    assign bus.op     = op;
    assign bus.tos    = tos;
    assign bus.rd_reg = rd_reg;
    assign bus.wr_reg = wr_reg;
    assign bus.wr_evt = wr_evt;

    //////////////////////////////////////////////////
    // blocks

    ctrl_status_regs #(
        .FPGA_ID  (FPGA_ID),
        .CLOCK_ID (CLOCK_ID),
        .FPGA_VER (FPGA_VER)
    ) u_regs (
        .cpu_clk  (cpu_clk),
        .reset    (reset),
        .bus      (bus.regs),
        .adc_ovfl (adc_ovfl),
        .ctrl     (ctrl),
        .status   (status)
    );

    cycle_counters u_counters (
        .cpu_clk (cpu_clk),
        .reset   (reset),
        .bus     (bus.counters),
        .ctr0    (ctr0),
        .ctr1    (ctr1)
    );

    cpu_read_port u_reader (
        .cpu_clk   (cpu_clk),
        .reset     (reset),
        .bus       (bus.reader),
        .status    (status),
        .ctr0      (ctr0),
        .ctr1      (ctr1),
        .host_dout (host_dout),
        .host_srq  (host_srq),
        .par       (par),
        .ser       (ser)
    );

    // board-level control outputs
    assign osc_en    = ctrl[io_pkg::CTRL_OSC_EN];
    assign eeprom_wp = ctrl[io_pkg::CTRL_EEPROM_WP];
    assign interrupt = ctrl[io_pkg::CTRL_INTERRUPT];

endmodule

// ==== cpu_read_port.sv ====
module cpu_read_port (
    input  logic           cpu_clk,
    input  logic           reset,
    cpu_bus_if.reader      bus,
    input  io_pkg::word_t  status,
    input  io_pkg::count_t ctr0,
    input  io_pkg::count_t ctr1,
    input  io_pkg::word_t  host_dout,
    input  logic           host_srq,
    output io_pkg::word_t  par,
    output logic           ser
);

    // service request seen since the last GET_SRQ read
    logic srq_noted;
    logic get_srq;

    // byte k of both counters, ctr1 high and ctr0 low
    function automatic io_pkg::word_t ctr_pair(input int k);
        io_pkg::word_t pair;
        pair = {
            ctr1[io_pkg::BYTE_W*k +: io_pkg::BYTE_W],
            ctr0[io_pkg::BYTE_W*k +: io_pkg::BYTE_W]
        };
        return pair;
    endfunction

    //////////////////////////////////////////////////
    // parallel input mux

    // priority: counter bytes, status, then host data
    always_comb
    begin
        if (bus.rd_reg && bus.op[io_pkg::OP_GET_CPU_CTR0])
            par = ctr_pair(0);
        else if (bus.rd_reg && bus.op[io_pkg::OP_GET_CPU_CTR1])
            par = ctr_pair(1);
        else if (bus.rd_reg && bus.op[io_pkg::OP_GET_CPU_CTR2])
            par = ctr_pair(2);
        else if (bus.rd_reg && bus.op[io_pkg::OP_GET_CPU_CTR3])
            par = ctr_pair(3);
        else if (bus.rd_reg && bus.op[io_pkg::OP_GET_STATUS])
            par = status;
        else
            // nothing local selected, host data falls through
            par = host_dout;
    end

    //////////////////////////////////////////////////
    // host service request capture

    assign get_srq = bus.rd_reg && bus.op[io_pkg::OP_GET_SRQ];

    always_ff @(posedge cpu_clk)
    begin
        if (reset)
        begin
            srq_noted <= 1'b0;
            ser       <= 1'b0;
        end
        else if (get_srq)
        begin
            // hand the accumulated bit to the serial input
            ser       <= srq_noted;
            // restart from the request present now
            srq_noted <= host_srq;
        end
        else
        begin
            srq_noted <= srq_noted | host_srq;
        end
    end

endmodule

// ==== cycle_counters.sv ====
module cycle_counters (
    input  logic           cpu_clk,
    input  logic           reset,
    cpu_bus_if.counters    bus,
    output io_pkg::count_t ctr0,
    output io_pkg::count_t ctr1
);

    // event-write commands
    logic ctr_clr;
    logic ctr_ena;
    logic ctr_dis;

    // counter 1 gate
    logic ena;

    assign ctr_clr = bus.wr_evt && bus.op[io_pkg::OP_CPU_CTR_CLR];
    assign ctr_ena = bus.wr_evt && bus.op[io_pkg::OP_CPU_CTR_ENA];
    assign ctr_dis = bus.wr_evt && bus.op[io_pkg::OP_CPU_CTR_DIS];

    //////////////////////////////////////////////////
    // enable flag

    always_ff @(posedge cpu_clk)
    begin
        if (reset)
        begin
            ena <= 1'b0;
        end
        else if (ctr_dis)
        begin
            // disable wins if both commands arrive together
            ena <= 1'b0;
        end
        else if (ctr_ena)
        begin
            ena <= 1'b1;
        end
    end

    //////////////////////////////////////////////////
    // counters

    // ctr0 counts every cpu cycle
    // ctr1 counts only cycles inside an enabled section
    always_ff @(posedge cpu_clk)
    begin
        if (reset || ctr_clr)
        begin
            ctr0 <= '0;
            ctr1 <= '0;
        end
        else
        begin
            ctr0 <= ctr0 + io_pkg::count_t'(1);
            // gate takes effect on the edge after the command
            ctr1 <= ctr1 + io_pkg::count_t'(ena);
        end
    end

endmodule

// ==== ctrl_status_regs.sv ====
module ctrl_status_regs #(
    parameter logic [io_pkg::ID_W-1:0] FPGA_ID  = '0,
    parameter logic [io_pkg::ID_W-1:0] CLOCK_ID = '0,
    parameter logic [io_pkg::ID_W-1:0] FPGA_VER = '0
) (
    input  logic          cpu_clk,
    input  logic          reset,
    cpu_bus_if.regs       bus,
    input  logic          adc_ovfl,
    output io_pkg::word_t ctrl,
    output io_pkg::word_t status
);

    // decoded strobes
    logic set_ctrl;
    logic clr_ovfl;

    // sticky adc overflow
    logic rx_overflow;

    assign set_ctrl = bus.wr_reg && bus.op[io_pkg::OP_SET_CTRL];
    assign clr_ovfl = bus.wr_evt && bus.op[io_pkg::OP_CLR_RX_OVFL];

    //////////////////////////////////////////////////
    // control register

    always_ff @(posedge cpu_clk)
    begin
        if (reset)
        begin
            // oscillator off, eeprom unprotected, no interrupt
            ctrl <= '0;
        end
        else if (set_ctrl)
        begin
            // only the low half of tos is a register value
            ctrl <= bus.tos[io_pkg::WORD_W-1:0];
        end
    end

    //////////////////////////////////////////////////
    // overflow flag

    always_ff @(posedge cpu_clk)
    begin
        if (reset)
        begin
            rx_overflow <= 1'b0;
        end
        else if (clr_ovfl)
        begin
            // clear, but keep an overflow arriving on the same edge
            rx_overflow <= adc_ovfl;
        end
        else
        begin
            // hold until the cpu clears it
            rx_overflow <= rx_overflow | adc_ovfl;
        end
    end

    //////////////////////////////////////////////////
    // status word

    // flag on top, pad, then version, clock and fpga ids
    assign status = {
        rx_overflow,
        {io_pkg::STATUS_PAD_W{1'b0}},
        FPGA_VER,
        CLOCK_ID,
        FPGA_ID
    };

endmodule

// ==== cpu_bus_if.sv ====
interface cpu_bus_if;

    // decoded instruction word, op bits select the register
    io_pkg::op_t    op;
    // top of stack, source of register writes
    io_pkg::stack_t tos;

    // one-cycle strobes from the cpu
    logic           rd_reg;
    logic           wr_reg;
    logic           wr_evt;

    // control and status registers
    modport regs (
        input op,
        input tos,
        input wr_reg,
        input wr_evt
    );

    // counter commands only come as event writes
    modport counters (
        input op,
        input wr_evt
    );

    // parallel and serial input selection
    modport reader (
        input op,
        input rd_reg
    );

endinterface

// ==== io_pkg.sv ====
package io_pkg;

    //////////////////////////////////////////////////
    // widths

    localparam int WORD_W  = 16;
    localparam int STACK_W = 32;
    localparam int OP_W    = 16;
    localparam int COUNT_W = 32;
    localparam int BYTE_W  = 8;

    // one identifier nibble in the status word
    localparam int ID_W = 4;
    // zero bits between the overflow flag and the identifiers
    localparam int STATUS_PAD_W = WORD_W - 1 - 3 * ID_W;

    //////////////////////////////////////////////////
    // vector types

    typedef logic [WORD_W-1:0]  word_t;
    typedef logic [STACK_W-1:0] stack_t;
    typedef logic [OP_W-1:0]    op_t;
    typedef logic [COUNT_W-1:0] count_t;

    //////////////////////////////////////////////////
    // op bits of the decoded instruction word

    // register write
    localparam int OP_SET_CTRL     = 0;
    // register reads
    localparam int OP_GET_STATUS   = 1;
    localparam int OP_GET_SRQ      = 3;
    localparam int OP_GET_CPU_CTR0 = 4;
    localparam int OP_GET_CPU_CTR1 = 5;
    localparam int OP_GET_CPU_CTR2 = 6;
    localparam int OP_GET_CPU_CTR3 = 7;
    // event writes
    localparam int OP_CLR_RX_OVFL  = 2;
    localparam int OP_CPU_CTR_CLR  = 8;
    localparam int OP_CPU_CTR_ENA  = 9;
    localparam int OP_CPU_CTR_DIS  = 10;

    //////////////////////////////////////////////////
    // control word bits, driven to the board

    localparam int CTRL_OSC_EN    = 0;
    localparam int CTRL_EEPROM_WP = 1;
    localparam int CTRL_INTERRUPT = 2;

endpackage
